// File: hdl/md_dl_pkg.sv
/*
 Shared definitions for the Mega Drive download front end
   download bus widths and index kinds
   ROM header byte addresses
   region and region priority codes
   cheat code layout, seen as fields or as download words
*/
package md_dl_pkg;

	// Download bus
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 16;

	localparam logic [4:0] DL_INDEX_CART  = 5'd1;
	localparam logic [7:0] DL_INDEX_CHEAT = 8'hFF;

	// Header region field and end of header
	localparam logic [DL_ADDR_W-1:0] HDR_REGION_ADDR  = 25'h1F0;
	localparam logic [DL_ADDR_W-1:0] HDR_REGION2_ADDR = 25'h1F2;
	localparam logic [DL_ADDR_W-1:0] HDR_END_ADDR     = 25'h200;

	// Console regions
	localparam logic [1:0] REGION_JP = 2'd0;
	localparam logic [1:0] REGION_US = 2'd1;
	localparam logic [1:0] REGION_EU = 2'd2;

	// Header priority orders, first choice named first
	localparam logic [1:0] PRIO_UEJ = 2'd0;
	localparam logic [1:0] PRIO_EUJ = 2'd1;
	localparam logic [1:0] PRIO_UJE = 2'd2;
	localparam logic [1:0] PRIO_JUE = 2'd3;

	// Game Genie style code, fields from the top down
	typedef union packed {
		struct packed {
			logic [31:0] flags;
			logic [31:0] addr;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
		logic [7:0][15:0] words;
	} cheat_code_u;

endpackage

// File: hdl/cart_header_scan.sv
/*
 Cartridge header scanner
   region letters J, U, E and the hex digit mask form
   sticky region flags, cleared when a cartridge download starts
   header ready level, set at the end of the header
*/
`timescale 1ns/10ps

module cart_header_scan (
	input  logic                             clk_sys,
	input  logic                             sys_reset,
	input  logic                             dl_active_i,
	input  logic [7:0]                       dl_index_i,
	input  logic                             dl_wr_i,
	input  logic [md_dl_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [md_dl_pkg::DL_DATA_W-1:0]  dl_data_i,
	output logic                             hdr_j_o,
	output logic                             hdr_u_o,
	output logic                             hdr_e_o,
	output logic                             hdr_ready_o
);

	logic       cart_dl;
	logic       cart_dl_q;
	logic       hdr_wr;
	logic [2:0] rgn_q;
	logic [2:0] rgn_d;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hex_val;

	// Flag bit per region letter, {E, U, J}
	function automatic logic [2:0] letter_mask(input logic [7:0] c);
		case (c)
			"J":     letter_mask = 3'b001;
			"U":     letter_mask = 3'b010;
			"E":     letter_mask = 3'b100;
			default: letter_mask = 3'b000;
		endcase
	endfunction

	assign cart_dl = dl_active_i && (dl_index_i[4:0] == md_dl_pkg::DL_INDEX_CART);
	assign hdr_wr  = cart_dl && dl_wr_i;
	assign lo_byte = dl_data_i[7:0];
	assign hi_byte = dl_data_i[15:8];
	// A to F land on 10 to 15
	assign hex_val = lo_byte[3:0] - 4'd7;

	always_comb begin
		rgn_d = rgn_q;
		if (hdr_wr && dl_addr_i == md_dl_pkg::HDR_REGION_ADDR) begin
			if (letter_mask(lo_byte) != 3'b000) begin
				rgn_d = rgn_q | letter_mask(lo_byte);
			end else if (lo_byte >= "0" && lo_byte <= "9") begin
				rgn_d = {lo_byte[3], lo_byte[2], lo_byte[0]};
			end else if (lo_byte >= "A" && lo_byte <= "F") begin
				rgn_d = {hex_val[3], hex_val[2], hex_val[0]};
			end
			rgn_d = rgn_d | letter_mask(hi_byte);
		end
		if (hdr_wr && dl_addr_i == md_dl_pkg::HDR_REGION2_ADDR) begin
			rgn_d = rgn_q | letter_mask(lo_byte);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_q   <= 1'b0;
			rgn_q       <= 3'b000;
			hdr_ready_o <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && !cart_dl_q) begin
				rgn_q <= 3'b000;
			end else begin
				rgn_q <= rgn_d;
			end
			if (!cart_dl && cart_dl_q) begin
				hdr_ready_o <= 1'b0;
			end else if (hdr_wr && dl_addr_i == md_dl_pkg::HDR_END_ADDR) begin
				hdr_ready_o <= 1'b1;
			end
		end
	end

	assign hdr_j_o = rgn_q[0];
	assign hdr_u_o = rgn_q[1];
	assign hdr_e_o = rgn_q[2];

endmodule

// File: hdl/region_select.sv
/*
 Console region selection
   priority order lookup over the header flags
   region from the download index as an alternative
   region set level, held while the header stays ready
*/
`timescale 1ns/10ps

module region_select (
	input  logic       clk_sys,
	input  logic       sys_reset,
	input  logic       hdr_j_i,
	input  logic       hdr_u_i,
	input  logic       hdr_e_i,
	input  logic       hdr_ready_i,
	input  logic       auto_region_i,
	input  logic       use_index_i,
	input  logic [1:0] priority_i,
	input  logic [7:0] dl_index_i,
	output logic [1:0] region_o,
	output logic       region_set_o
);

	logic       ready_q;
	logic [2:0] hdr_flags;
	logic [5:0] order;
	logic [1:0] pick;

	// Indexed by region code
	assign hdr_flags = {hdr_e_i, hdr_u_i, hdr_j_i};

	// First choice in the top two bits
	always_comb begin
		case (priority_i)
			md_dl_pkg::PRIO_UEJ:
				order = {md_dl_pkg::REGION_US, md_dl_pkg::REGION_EU, md_dl_pkg::REGION_JP};
			md_dl_pkg::PRIO_EUJ:
				order = {md_dl_pkg::REGION_EU, md_dl_pkg::REGION_US, md_dl_pkg::REGION_JP};
			md_dl_pkg::PRIO_UJE:
				order = {md_dl_pkg::REGION_US, md_dl_pkg::REGION_JP, md_dl_pkg::REGION_EU};
			md_dl_pkg::PRIO_JUE:
				order = {md_dl_pkg::REGION_JP, md_dl_pkg::REGION_US, md_dl_pkg::REGION_EU};
		endcase
	end

	always_comb begin
		if (hdr_flags[order[5:4]]) begin
			pick = order[5:4];
		end else if (hdr_flags[order[3:2]]) begin
			pick = order[3:2];
		end else if (hdr_flags[order[1:0]]) begin
			pick = order[1:0];
		end else begin
			// No marker at all
			pick = order[5:4];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ready_q      <= 1'b0;
			region_o     <= md_dl_pkg::REGION_JP;
			region_set_o <= 1'b0;
		end else begin
			ready_q <= hdr_ready_i;
			if (auto_region_i && hdr_ready_i && !ready_q) begin
				if (use_index_i) begin
					region_set_o <= |dl_index_i;
					region_o     <= dl_index_i[7:6];
				end else begin
					region_set_o <= 1'b1;
					region_o     <= pick;
				end
			end
			if (!hdr_ready_i && ready_q) begin
				region_set_o <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/cheat_code_loader.sv
/*
 Cheat code loader
   eight 16-bit download words into one 128-bit code
   one-cycle valid strobe after the last replace word
*/
`timescale 1ns/10ps

module cheat_code_loader (
	input  logic                             clk_sys,
	input  logic                             sys_reset,
	input  logic                             dl_active_i,
	input  logic [7:0]                       dl_index_i,
	input  logic                             dl_wr_i,
	input  logic [md_dl_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [md_dl_pkg::DL_DATA_W-1:0]  dl_data_i,
	output md_dl_pkg::cheat_code_u           code_o,
	output logic                             code_valid_o
);

	logic       cheat_wr;
	logic [2:0] word_sel;

	// Byte offsets are even, one word per write
	assign cheat_wr = dl_active_i && (dl_index_i == md_dl_pkg::DL_INDEX_CHEAT)
		&& dl_wr_i && !dl_addr_i[0];

	// Each field arrives low word first, fields in flags to replace order
	assign word_sel = {~dl_addr_i[3], ~dl_addr_i[2], dl_addr_i[1]};

	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			code_o.words[word_sel] <= dl_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			code_valid_o <= 1'b0;
		end else begin
			// Replace top word closes the code
			code_valid_o <= cheat_wr && (dl_addr_i[3:0] == 4'hE);
		end
	end

endmodule

// File: hdl/backup_ram_seq.sv
/*
 Backup RAM save and load sequencer
   enable from a writable image mounted during a cartridge download
   manual load and save triggers, automatic load after download
   one sector request per block until SAVE_BLOCKS blocks are done
*/
`timescale 1ns/10ps

module backup_ram_seq #(
	parameter int SAVE_BLOCKS = 128
) (
	input  logic        clk_sys,
	input  logic        sys_reset,
	input  logic        dl_active_i,
	input  logic [7:0]  dl_index_i,
	input  logic        img_mounted_i,
	input  logic        img_readonly_i,
	input  logic        img_size_nz_i,
	input  logic        bk_load_i,
	input  logic        bk_save_i,
	input  logic        sd_ack_i,
	output logic [31:0] sd_lba_o,
	output logic        sd_rd_o,
	output logic        sd_wr_o,
	output logic        bk_busy_o,
	output logic        bk_loading_o
);

	localparam int              BLK_W    = $clog2(SAVE_BLOCKS);
	localparam logic [BLK_W-1:0] LAST_BLK = BLK_W'(SAVE_BLOCKS - 1);

	logic             cart_dl;
	logic             cart_dl_q;
	logic             load_q;
	logic             save_q;
	logic             ack_q;
	logic             bk_ena;
	logic [BLK_W-1:0] blk_q;

	assign cart_dl  = dl_active_i && (dl_index_i[4:0] == md_dl_pkg::DL_INDEX_CART);
	assign sd_lba_o = 32'(blk_q);

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_q    <= 1'b0;
			load_q       <= 1'b0;
			save_q       <= 1'b0;
			ack_q        <= 1'b0;
			bk_ena       <= 1'b0;
			blk_q        <= '0;
			sd_rd_o      <= 1'b0;
			sd_wr_o      <= 1'b0;
			bk_busy_o    <= 1'b0;
			bk_loading_o <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			load_q    <= bk_load_i;
			save_q    <= bk_save_i;
			ack_q     <= sd_ack_i;

			// Save image gets mounted while the cartridge loads
			if (cart_dl && !cart_dl_q) begin
				bk_ena <= 1'b0;
			end
			if (cart_dl && img_mounted_i && !img_readonly_i) begin
				bk_ena <= 1'b1;
			end

			// Host took the request
			if (sd_ack_i && !ack_q) begin
				sd_rd_o <= 1'b0;
				sd_wr_o <= 1'b0;
			end

			if (!bk_busy_o) begin
				if (bk_ena && ((bk_load_i && !load_q) || (bk_save_i && !save_q))) begin
					bk_busy_o    <= 1'b1;
					bk_loading_o <= bk_load_i && !load_q;
					blk_q        <= '0;
					sd_rd_o      <= bk_load_i && !load_q;
					sd_wr_o      <= !(bk_load_i && !load_q);
				end
				// Auto load once the cartridge is in
				if (!cart_dl && cart_dl_q && img_size_nz_i && bk_ena) begin
					bk_busy_o    <= 1'b1;
					bk_loading_o <= 1'b1;
					blk_q        <= '0;
					sd_rd_o      <= 1'b1;
					sd_wr_o      <= 1'b0;
				end
			end else if (!sd_ack_i && ack_q) begin
				if (blk_q == LAST_BLK) begin
					bk_busy_o    <= 1'b0;
					bk_loading_o <= 1'b0;
				end else begin
					blk_q   <= blk_q + BLK_W'(1);
					sd_rd_o <= bk_loading_o;
					sd_wr_o <= !bk_loading_o;
				end
			end
		end
	end

endmodule

// File: hdl/md_download_top.sv
/*
 Download front end top level
   header scan feeding region select
   cheat code loader
   backup RAM sequencer, SAVE_BLOCKS set here
*/
`timescale 1ns/10ps

module md_download_top #(
	parameter int SAVE_BLOCKS = 128
) (
	input  logic                             clk_sys,
	input  logic                             sys_reset,
	input  logic                             dl_active_i,
	input  logic [7:0]                       dl_index_i,
	input  logic                             dl_wr_i,
	input  logic [md_dl_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [md_dl_pkg::DL_DATA_W-1:0]  dl_data_i,
	input  logic                             auto_region_i,
	input  logic                             use_index_i,
	input  logic [1:0]                       priority_i,
	input  logic                             img_mounted_i,
	input  logic                             img_readonly_i,
	input  logic                             img_size_nz_i,
	input  logic                             bk_load_i,
	input  logic                             bk_save_i,
	input  logic                             sd_ack_i,
	output logic [1:0]                       region_o,
	output logic                             region_set_o,
	output md_dl_pkg::cheat_code_u           code_o,
	output logic                             code_valid_o,
	output logic [31:0]                      sd_lba_o,
	output logic                             sd_rd_o,
	output logic                             sd_wr_o,
	output logic                             bk_busy_o,
	output logic                             bk_loading_o
);

	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	//////////////////////////////
	// Region
	cart_header_scan u_hdr (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i),
		.hdr_j_o(hdr_j), .hdr_u_o(hdr_u), .hdr_e_o(hdr_e), .hdr_ready_o(hdr_ready)
	);

	region_select u_region (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.hdr_j_i(hdr_j), .hdr_u_i(hdr_u), .hdr_e_i(hdr_e), .hdr_ready_i(hdr_ready),
		.auto_region_i(auto_region_i), .use_index_i(use_index_i),
		.priority_i(priority_i), .dl_index_i(dl_index_i),
		.region_o(region_o), .region_set_o(region_set_o)
	);

	//////////////////////////////
	// Cheats
	cheat_code_loader u_cheat (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i),
		.code_o(code_o), .code_valid_o(code_valid_o)
	);

	//////////////////////////////
	// Backup RAM
	backup_ram_seq #(.SAVE_BLOCKS(SAVE_BLOCKS)) u_bkram (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i),
		.img_mounted_i(img_mounted_i), .img_readonly_i(img_readonly_i),
		.img_size_nz_i(img_size_nz_i), .bk_load_i(bk_load_i), .bk_save_i(bk_save_i),
		.sd_ack_i(sd_ack_i), .sd_lba_o(sd_lba_o), .sd_rd_o(sd_rd_o), .sd_wr_o(sd_wr_o),
		.bk_busy_o(bk_busy_o), .bk_loading_o(bk_loading_o)
	);

endmodule

// File: tb/tb_tasks.svh
/*
 Testbench tasks
   download bus and sector handshake drivers
   compare tasks for bits, regions, cheat codes and counts
   directed tests for region, cheats and backup RAM
*/

task automatic abort_run();
	$display("RESULT: FAIL");
	$fatal(1, "simulation stopped at the first error");
endtask

//////////////////////////////
// Compare tasks

task automatic check_bit(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_region(input logic [1:0] got, input logic [1:0] exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_code(input md_dl_pkg::cheat_code_u got,
		input md_dl_pkg::cheat_code_u exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[ERROR] %0t ns: %s is %h %h %h %h, expected %h %h %h %h", $time, what,
			got.fields.flags, got.fields.addr, got.fields.compare, got.fields.replace,
			exp.fields.flags, exp.fields.addr, exp.fields.compare, exp.fields.replace);
		abort_run();
	end
endtask

task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		abort_run();
	end
endtask

//////////////////////////////
// Drivers

task automatic begin_download(input logic [7:0] index);
	@(posedge clk_sys);
	dl_active_i <= 1'b1;
	dl_index_i  <= index;
endtask

task automatic end_download();
	@(posedge clk_sys);
	dl_active_i <= 1'b0;
endtask

task automatic dl_write(input logic [md_dl_pkg::DL_ADDR_W-1:0] addr, input logic [15:0] data);
	@(posedge clk_sys);
	dl_wr_i   <= 1'b1;
	dl_addr_i <= addr;
	dl_data_i <= data;
	@(posedge clk_sys);
	dl_wr_i <= 1'b0;
endtask

// Host side of the sector handshake, random ack latency
task automatic serve_blocks(input logic writing, output logic [31:0] blocks);
	logic [31:0] rnd;
	blocks = 0;
	@(negedge clk_sys);
	while (!bk_busy_o) @(negedge clk_sys);
	while (bk_busy_o) begin
		if (sd_rd_o || sd_wr_o) begin
			check_bit(sd_wr_o, writing, "sector write request");
			check_bit(sd_rd_o, !writing, "sector read request");
			check_bit(bk_loading_o, !writing, "backup loading flag");
			check_count(sd_lba_o, blocks, "sector block address");
			rnd = $random(seed);
			repeat (rnd[1:0]) @(posedge clk_sys);
			@(posedge clk_sys);
			sd_ack_i <= 1'b1;
			@(negedge clk_sys);
			while (sd_rd_o || sd_wr_o) @(negedge clk_sys);
			@(posedge clk_sys);
			sd_ack_i <= 1'b0;
			blocks = blocks + 1;
		end
		@(negedge clk_sys);
	end
endtask

// Cartridge with a header, then the region once the header is in
task automatic run_header_case(input logic [7:0] index, input logic [15:0] region_word,
		input logic [15:0] region2_word, input logic [1:0] prio, input logic by_index,
		input logic [1:0] exp_region, input string what);
	@(posedge clk_sys);
	priority_i  <= prio;
	use_index_i <= by_index;
	begin_download(index);
	dl_write(25'h100, {"S", "E"});
	dl_write(md_dl_pkg::HDR_REGION_ADDR, region_word);
	dl_write(md_dl_pkg::HDR_REGION2_ADDR, region2_word);
	dl_write(md_dl_pkg::HDR_END_ADDR, 16'h0000);
	@(negedge clk_sys);
	while (!region_set_o) @(negedge clk_sys);
	check_region(region_o, exp_region, what);
	end_download();
	@(negedge clk_sys);
	while (region_set_o) @(negedge clk_sys);
endtask

//////////////////////////////
// Directed tests

task automatic test_reset_state();
	@(negedge clk_sys);
	check_bit(region_set_o, 1'b0, "region set after reset");
	check_bit(code_valid_o, 1'b0, "code valid after reset");
	check_bit(sd_rd_o, 1'b0, "sector read after reset");
	check_bit(sd_wr_o, 1'b0, "sector write after reset");
	check_bit(bk_busy_o, 1'b0, "backup busy after reset");
endtask

task automatic test_letter_priority();
	// Low byte U, high byte E
	run_header_case(8'h01, {"E", "U"}, 16'h2020, md_dl_pkg::PRIO_EUJ, 1'b0,
		md_dl_pkg::REGION_EU, "region from letters");
endtask

task automatic test_hex_digit();
	// C is a mask with US and EU set
	run_header_case(8'h01, {" ", "C"}, 16'h2020, md_dl_pkg::PRIO_UJE, 1'b0,
		md_dl_pkg::REGION_US, "region from hex digit");
endtask

task automatic test_no_markers();
	logic [7:0] idx;
	idx = 8'h81;
	run_header_case(8'h01, 16'h2020, 16'h2020, md_dl_pkg::PRIO_JUE, 1'b0,
		md_dl_pkg::REGION_JP, "region without markers");
	// Index bits override the J and U letters
	run_header_case(idx, {"U", "J"}, 16'h2020, md_dl_pkg::PRIO_JUE, 1'b1,
		idx[7:6], "region from index");
endtask

task automatic test_cheat_assembly();
	logic [15:0]            w [8];
	logic [31:0]            rnd;
	md_dl_pkg::cheat_code_u exp;
	int                     start_pulses;
	start_pulses = valid_pulses;
	begin_download(md_dl_pkg::DL_INDEX_CHEAT);
	for (int k = 0; k < 8; k++) begin
		rnd  = $random(seed);
		w[k] = rnd[15:0];
		dl_write(25'(2 * k), w[k]);
	end
	@(negedge clk_sys);
	while (!code_valid_o) @(negedge clk_sys);
	// Fields in download order, low word first
	exp.fields.flags   = {w[1], w[0]};
	exp.fields.addr    = {w[3], w[2]};
	exp.fields.compare = {w[5], w[4]};
	exp.fields.replace = {w[7], w[6]};
	check_code(code_o, exp, "cheat code");
	end_download();
	repeat (4) @(negedge clk_sys);
	check_count(32'(valid_pulses - start_pulses), 32'd1, "cheat valid pulses");
endtask

task automatic test_save_sequence();
	logic [31:0] blocks;
	@(posedge clk_sys);
	img_mounted_i  <= 1'b1;
	img_readonly_i <= 1'b0;
	img_size_nz_i  <= 1'b0;
	begin_download(8'h01);
	dl_write(25'h100, {"S", "E"});
	end_download();
	@(posedge clk_sys);
	bk_save_i <= 1'b1;
	@(posedge clk_sys);
	bk_save_i <= 1'b0;
	serve_blocks(1'b1, blocks);
	check_count(blocks, 32'(SAVE_BLOCKS), "saved blocks");
	check_bit(sd_wr_o, 1'b0, "sector write after save");
	repeat (4) @(negedge clk_sys);
	check_bit(bk_busy_o, 1'b0, "backup busy after save");
endtask

task automatic test_auto_load();
	logic [31:0] blocks;
	@(posedge clk_sys);
	img_size_nz_i <= 1'b1;
	begin_download(8'h01);
	dl_write(25'h100, {"S", "E"});
	end_download();
	serve_blocks(1'b0, blocks);
	check_count(blocks, 32'(SAVE_BLOCKS), "loaded blocks");
	check_bit(sd_rd_o, 1'b0, "sector read after load");
	repeat (4) @(negedge clk_sys);
	check_bit(bk_busy_o, 1'b0, "backup busy after load");
endtask

// File: tb/tb_md_download.sv
/*
 Testbench top for the download front end
   clock, reset and DUT instance
   cycle watchdog sized from the test lengths
   directed test sequence and final result
*/
`timescale 1ns/10ps

module tb_md_download;

	localparam int SAVE_BLOCKS = 128;
	// Rough cycle cost of each test step
	localparam int DL_CYCLES    = 24;
	localparam int CHEAT_CYCLES = 32;
	localparam int BLOCK_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = 2 * (10 + 4 * DL_CYCLES + CHEAT_CYCLES
		+ 2 * (DL_CYCLES + SAVE_BLOCKS * BLOCK_CYCLES));

	logic                            clk_sys;
	logic                            sys_reset;
	logic                            dl_active_i;
	logic [7:0]                      dl_index_i;
	logic                            dl_wr_i;
	logic [md_dl_pkg::DL_ADDR_W-1:0] dl_addr_i;
	logic [md_dl_pkg::DL_DATA_W-1:0] dl_data_i;
	logic                            auto_region_i;
	logic                            use_index_i;
	logic [1:0]                      priority_i;
	logic                            img_mounted_i;
	logic                            img_readonly_i;
	logic                            img_size_nz_i;
	logic                            bk_load_i;
	logic                            bk_save_i;
	logic                            sd_ack_i;
	logic [1:0]                      region_o;
	logic                            region_set_o;
	md_dl_pkg::cheat_code_u          code_o;
	logic                            code_valid_o;
	logic [31:0]                     sd_lba_o;
	logic                            sd_rd_o;
	logic                            sd_wr_o;
	logic                            bk_busy_o;
	logic                            bk_loading_o;

	integer seed;
	int     cycle_count;
	int     valid_pulses;
	int     error_count;

	md_download_top #(.SAVE_BLOCKS(SAVE_BLOCKS)) dut0 (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i),
		.auto_region_i(auto_region_i), .use_index_i(use_index_i), .priority_i(priority_i),
		.img_mounted_i(img_mounted_i), .img_readonly_i(img_readonly_i),
		.img_size_nz_i(img_size_nz_i), .bk_load_i(bk_load_i), .bk_save_i(bk_save_i),
		.sd_ack_i(sd_ack_i), .region_o(region_o), .region_set_o(region_set_o),
		.code_o(code_o), .code_valid_o(code_valid_o), .sd_lba_o(sd_lba_o),
		.sd_rd_o(sd_rd_o), .sd_wr_o(sd_wr_o), .bk_busy_o(bk_busy_o),
		.bk_loading_o(bk_loading_o)
	);

	`include "tb_tasks.svh"

	always #2 clk_sys = ~clk_sys;

	// Watchdog
	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			abort_run();
		end
	end

	// Strobes seen mid cycle, away from the driving edge
	always @(negedge clk_sys) begin
		if (code_valid_o) begin
			valid_pulses = valid_pulses + 1;
		end
	end

	initial begin
		clk_sys = 1'b0;
		seed    = 24610;
		sys_reset      <= 1'b1;
		dl_active_i    <= 1'b0;
		dl_index_i     <= 8'h00;
		dl_wr_i        <= 1'b0;
		dl_addr_i      <= '0;
		dl_data_i      <= '0;
		auto_region_i  <= 1'b1;
		use_index_i    <= 1'b0;
		priority_i     <= md_dl_pkg::PRIO_UEJ;
		img_mounted_i  <= 1'b0;
		img_readonly_i <= 1'b0;
		img_size_nz_i  <= 1'b0;
		bk_load_i      <= 1'b0;
		bk_save_i      <= 1'b0;
		sd_ack_i       <= 1'b0;
		repeat (5) @(posedge clk_sys);
		sys_reset <= 1'b0;

		test_reset_state();
		test_letter_priority();
		test_hex_digit();
		test_no_markers();
		test_cheat_assembly();
		test_save_sequence();
		test_auto_load();

		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+tb
hdl/md_dl_pkg.sv
hdl/cart_header_scan.sv
hdl/region_select.sv
hdl/cheat_code_loader.sv
hdl/backup_ram_seq.sv
hdl/md_download_top.sv
tb/tb_md_download.sv

// File: Makefile
# Verilator lint and simulation of the download front end

VERILATOR ?= verilator
TOP       ?= tb_md_download
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
